/* hazard_defs.svh */
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// ========================================
// Pipeline geometry
// ========================================

// General register address width.
`define REG_ADDR_W 5

// IF, ID, EXE, MEM and WB.
`define NUM_STAGES 5

// ========================================
// EXE operation codes
// ========================================

// EXE operation with no effect on any register.
`define EXE_OP_NOP 5'd0

`endif

/* isa_pkg.sv */
package isa_pkg;

    // ========================================
    // Control fields carried down the pipe
    // ========================================

    typedef enum logic [2:0] {
        ID_NONE   = 3'd0,
        ID_BRANCH = 3'd1,
        ID_JALR   = 3'd2,
        ID_EBREAK = 3'd3,
        ID_OTHER  = 3'd4
    } id_class_e;

    typedef enum logic [3:0] {
        WB_NONE   = 4'd0,
        WB_EXE    = 4'd1,
        WB_MEM    = 4'd2,
        WB_IMM    = 4'd3,
        WB_SNPC   = 4'd4,
        WB_CSRRW  = 4'd5,
        WB_CSRRS  = 4'd6,
        WB_CSRRWI = 4'd7,
        WB_ECALL  = 4'd8  // Touches CSRs only.
    } wb_sel_e;

    typedef enum logic [2:0] {
        SRC_NOP, SRC_R_R, SRC_R_I, SRC_PC_I,
        SRC_R_CSR, SRC_NOTR_CSR, SRC_CSR_ZIMM, SRC_CSR_NOTZIMM
    } exe_src_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU,
        MEM_SB, MEM_SH, MEM_SW, MEM_SD  // Stores read rs2.
    } mem_op_e;

endpackage

/* hazard_pkg.sv */
package hazard_pkg;

    // One stage's gating result.
    typedef struct packed {
        logic valid;   // Low inserts a bubble.
        logic enable;  // Low holds the stage register.
    } gate_t;

    // Gating for the whole pipe, front to back.
    typedef struct packed {
        gate_t if_g;
        gate_t id_g;
        gate_t exe_g;
        gate_t mem_g;
        gate_t wb_g;
    } stage_gates_t;

endpackage

/* stage_use_if.sv */
`timescale 1ns/1ps

interface stage_use_if;

    // Source register reads per stage.
    logic id_rs1_rd;
    logic id_rs2_rd;
    logic exe_rs1_rd;
    logic exe_rs2_rd;
    logic mem_rs2_rd;

    // Destination register writes per stage.
    logic exe_wr;
    logic mem_wr;
    logic wb_wr;

    modport producer (
        output id_rs1_rd, id_rs2_rd,
        output exe_rs1_rd, exe_rs2_rd,
        output mem_rs2_rd,
        output exe_wr, mem_wr, wb_wr
    );

    modport consumer (
        input id_rs1_rd, id_rs2_rd,
        input exe_rs1_rd, exe_rs2_rd,
        input mem_rs2_rd,
        input exe_wr, mem_wr, wb_wr
    );

endinterface

/* hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;

    logic id_dep;       // ID source still in flight.
    logic exe_dep;      // EXE source still in flight.
    logic mem_dep;      // Store data still in flight.
    logic id_reads;
    logic ebreak_hold;
    logic pipe_empty;   // Nothing behind ID.

    modport producer (
        output id_dep, exe_dep, mem_dep,
        output id_reads, ebreak_hold, pipe_empty
    );

    modport consumer (
        input id_dep, exe_dep, mem_dep,
        input id_reads, ebreak_hold, pipe_empty
    );

endinterface

/* reg_use_decoder.sv */
`timescale 1ns/1ps
`include "hazard_defs.svh"

module reg_use_decoder (
    input  logic                id_valid_in,
    input  isa_pkg::id_class_e  id_class,
    input  logic                exe_valid_in,
    input  logic [4:0]          exe_op,
    input  isa_pkg::exe_src_e   exe_src,
    input  isa_pkg::wb_sel_e    exe_wb_sel,
    input  logic                mem_valid_in,
    input  isa_pkg::mem_op_e    mem_op,
    input  isa_pkg::wb_sel_e    mem_wb_sel,
    input  logic                wb_valid_in,
    input  isa_pkg::wb_sel_e    wb_sel,
    stage_use_if.producer       usage
);

    logic exe_active;

    // Selects that land in the general register file.
    function automatic logic writes_rd(input isa_pkg::wb_sel_e sel);
        case (sel)
            isa_pkg::WB_EXE, isa_pkg::WB_MEM, isa_pkg::WB_IMM, isa_pkg::WB_SNPC,
            isa_pkg::WB_CSRRW, isa_pkg::WB_CSRRS, isa_pkg::WB_CSRRWI: begin
                return 1'b1;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    // ========================================
    // Read usage
    // ========================================

    assign usage.id_rs1_rd = id_valid_in &&
                             (id_class == isa_pkg::ID_BRANCH || id_class == isa_pkg::ID_JALR);
    assign usage.id_rs2_rd = id_valid_in && (id_class == isa_pkg::ID_BRANCH);

    assign exe_active = exe_valid_in && (exe_op != `EXE_OP_NOP);

    always_comb begin
        usage.exe_rs1_rd = 1'b0;
        usage.exe_rs2_rd = 1'b0;
        if (exe_active) begin
            case (exe_src)
                isa_pkg::SRC_R_R: begin
                    usage.exe_rs1_rd = 1'b1;
                    usage.exe_rs2_rd = 1'b1;
                end
                isa_pkg::SRC_R_I, isa_pkg::SRC_R_CSR, isa_pkg::SRC_NOTR_CSR: begin
                    usage.exe_rs1_rd = 1'b1;  // Immediate or CSR on the other side.
                end
                default: begin
                end
            endcase
        end
    end

    assign usage.mem_rs2_rd = mem_valid_in &&
                              (mem_op == isa_pkg::MEM_SB || mem_op == isa_pkg::MEM_SH ||
                               mem_op == isa_pkg::MEM_SW || mem_op == isa_pkg::MEM_SD);

    // ========================================
    // Write usage
    // ========================================

    assign usage.exe_wr = exe_valid_in && writes_rd(exe_wb_sel);
    assign usage.mem_wr = mem_valid_in && writes_rd(mem_wb_sel);
    assign usage.wb_wr  = wb_valid_in && writes_rd(wb_sel);

endmodule

/* dependency_matcher.sv */
`timescale 1ns/1ps
`include "hazard_defs.svh"

module dependency_matcher (
    stage_use_if.consumer          usage,
    input  logic                   id_valid_in,
    input  isa_pkg::id_class_e     id_class,
    input  logic                   exe_valid_in,
    input  logic                   mem_valid_in,
    input  logic                   wb_valid_in,
    input  logic [`REG_ADDR_W-1:0] id_rs1,
    input  logic [`REG_ADDR_W-1:0] id_rs2,
    input  logic [`REG_ADDR_W-1:0] exe_rd,
    input  logic [`REG_ADDR_W-1:0] exe_rs1,
    input  logic [`REG_ADDR_W-1:0] exe_rs2,
    input  logic [`REG_ADDR_W-1:0] mem_rd,
    input  logic [`REG_ADDR_W-1:0] mem_rs2,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    hazard_if.producer             haz
);

    logic id_rs1_hit;
    logic id_rs2_hit;
    logic exe_rs1_hit;
    logic exe_rs2_hit;
    logic mem_rs2_hit;

    // ========================================
    // Address compares
    // ========================================

    // ID sees writers in EXE, MEM and WB.
    assign id_rs1_hit = (usage.exe_wr && id_rs1 == exe_rd) ||
                        (usage.mem_wr && id_rs1 == mem_rd) ||
                        (usage.wb_wr && id_rs1 == wb_rd);
    assign id_rs2_hit = (usage.exe_wr && id_rs2 == exe_rd) ||
                        (usage.mem_wr && id_rs2 == mem_rd) ||
                        (usage.wb_wr && id_rs2 == wb_rd);

    // EXE sees writers in MEM and WB.
    assign exe_rs1_hit = (usage.mem_wr && exe_rs1 == mem_rd) ||
                         (usage.wb_wr && exe_rs1 == wb_rd);
    assign exe_rs2_hit = (usage.mem_wr && exe_rs2 == mem_rd) ||
                         (usage.wb_wr && exe_rs2 == wb_rd);

    assign mem_rs2_hit = usage.wb_wr && mem_rs2 == wb_rd;  // Store data only.

    // ========================================
    // Per-stage flags
    // ========================================

    assign haz.id_dep  = (usage.id_rs1_rd && id_rs1_hit) || (usage.id_rs2_rd && id_rs2_hit);
    assign haz.exe_dep = (usage.exe_rs1_rd && exe_rs1_hit) ||
                         (usage.exe_rs2_rd && exe_rs2_hit);
    assign haz.mem_dep = usage.mem_rs2_rd && mem_rs2_hit;

    assign haz.id_reads    = usage.id_rs1_rd || usage.id_rs2_rd;
    assign haz.ebreak_hold = id_valid_in && (id_class == isa_pkg::ID_EBREAK);
    assign haz.pipe_empty  = !exe_valid_in && !mem_valid_in && !wb_valid_in;

endmodule

/* stall_arbiter.sv */
`timescale 1ns/1ps

module stall_arbiter (
    hazard_if.consumer                haz,
    output hazard_pkg::stage_gates_t  gates,
    output logic                      halt
);

    logic front_hold;
    logic any_dep;
    logic back_dep;

    // ========================================
    // Hold conditions
    // ========================================

    assign front_hold = haz.id_dep || haz.ebreak_hold;    // Nothing new may enter.
    assign back_dep   = haz.exe_dep || haz.mem_dep;
    assign any_dep    = haz.id_dep || back_dep || haz.ebreak_hold;

    // ========================================
    // Stage gating
    // ========================================

    always_comb begin
        gates.if_g.valid   = !front_hold;
        gates.if_g.enable  = !any_dep;

        gates.id_g.valid   = !haz.id_reads;   // Resolved in ID, no result flows on.
        gates.id_g.enable  = !any_dep;

        gates.exe_g.valid  = !front_hold;     // Bubble behind a held ID.
        gates.exe_g.enable = !back_dep;

        gates.mem_g.valid  = !haz.exe_dep;
        gates.mem_g.enable = !haz.mem_dep;

        gates.wb_g.valid   = !haz.mem_dep;
        gates.wb_g.enable  = 1'b1;            // WB always retires.
    end

    // Pipe behind the ebreak has drained.
    assign halt = haz.ebreak_hold && haz.pipe_empty;

endmodule

/* conflict_detector.sv */
`timescale 1ns/1ps
`include "hazard_defs.svh"

module conflict_detector (
    input  logic                   id_valid_in,
    input  isa_pkg::id_class_e     id_class,
    input  logic [`REG_ADDR_W-1:0] id_rs1,
    input  logic [`REG_ADDR_W-1:0] id_rs2,

    input  logic                   exe_valid_in,
    input  logic [4:0]             exe_op,
    input  isa_pkg::exe_src_e      exe_src,
    input  isa_pkg::wb_sel_e       exe_wb_sel,
    input  logic [`REG_ADDR_W-1:0] exe_rd,
    input  logic [`REG_ADDR_W-1:0] exe_rs1,
    input  logic [`REG_ADDR_W-1:0] exe_rs2,

    input  logic                   mem_valid_in,
    input  isa_pkg::mem_op_e       mem_op,
    input  isa_pkg::wb_sel_e       mem_wb_sel,
    input  logic [`REG_ADDR_W-1:0] mem_rd,
    input  logic [`REG_ADDR_W-1:0] mem_rs2,

    input  logic                   wb_valid_in,
    input  isa_pkg::wb_sel_e       wb_sel,
    input  logic [`REG_ADDR_W-1:0] wb_rd,

    output logic                   if_valid,
    output logic                   if_enable,
    output logic                   id_valid,
    output logic                   id_enable,
    output logic                   exe_valid,
    output logic                   exe_enable,
    output logic                   mem_valid,
    output logic                   mem_enable,
    output logic                   wb_valid,
    output logic                   halt
);

    hazard_pkg::stage_gates_t gates;

    stage_use_if i_stage_use ();
    hazard_if    i_hazard ();

    // ========================================
    // Decode, match, arbitrate
    // ========================================

    reg_use_decoder i_decoder (
        .id_valid_in, .id_class,
        .exe_valid_in, .exe_op, .exe_src, .exe_wb_sel,
        .mem_valid_in, .mem_op, .mem_wb_sel,
        .wb_valid_in, .wb_sel,
        .usage (i_stage_use.producer)
    );

    dependency_matcher i_matcher (
        .usage (i_stage_use.consumer),
        .id_valid_in, .id_class, .exe_valid_in, .mem_valid_in, .wb_valid_in,
        .id_rs1, .id_rs2, .exe_rd, .exe_rs1, .exe_rs2, .mem_rd, .mem_rs2, .wb_rd,
        .haz   (i_hazard.producer)
    );

    stall_arbiter i_arbiter (
        .haz   (i_hazard.consumer),
        .gates (gates),
        .halt  (halt)
    );

    assign if_valid   = gates.if_g.valid;
    assign if_enable  = gates.if_g.enable;
    assign id_valid   = gates.id_g.valid;
    assign id_enable  = gates.id_g.enable;
    assign exe_valid  = gates.exe_g.valid;
    assign exe_enable = gates.exe_g.enable;
    assign mem_valid  = gates.mem_g.valid;
    assign mem_enable = gates.mem_g.enable;
    assign wb_valid   = gates.wb_g.valid;   // WB enable has no port.

endmodule

/* tb_conflict_detector.sv */
`timescale 1ns/1ps
`include "hazard_defs.svh"

module tb_conflict_detector;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_VECTORS = 2000;
    localparam int WATCHDOG_NS = NUM_VECTORS * CLK_PERIOD * 2;

    logic clk;
    logic rst;
    int   errors;

    logic                   id_valid_in, exe_valid_in, mem_valid_in, wb_valid_in;
    isa_pkg::id_class_e     id_class;
    logic [4:0]             exe_op;
    isa_pkg::exe_src_e      exe_src;
    isa_pkg::wb_sel_e       exe_wb_sel, mem_wb_sel, wb_sel;
    isa_pkg::mem_op_e       mem_op;
    logic [`REG_ADDR_W-1:0] id_rs1, id_rs2, exe_rd, exe_rs1, exe_rs2, mem_rd, mem_rs2, wb_rd;

    logic if_valid, if_enable, id_valid, id_enable, exe_valid, exe_enable;
    logic mem_valid, mem_enable, wb_valid, halt;

    conflict_detector i_dut (
        .id_valid_in, .id_class, .id_rs1, .id_rs2,
        .exe_valid_in, .exe_op, .exe_src, .exe_wb_sel, .exe_rd, .exe_rs1, .exe_rs2,
        .mem_valid_in, .mem_op, .mem_wb_sel, .mem_rd, .mem_rs2,
        .wb_valid_in, .wb_sel, .wb_rd,
        .if_valid, .if_enable, .id_valid, .id_enable, .exe_valid, .exe_enable,
        .mem_valid, .mem_enable, .wb_valid, .halt
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Reference model
    // ========================================

    // EXE through CSRRWI reach the register file.
    function automatic logic sel_writes(input isa_pkg::wb_sel_e sel);
        return (sel >= isa_pkg::WB_EXE) && (sel <= isa_pkg::WB_CSRRWI);
    endfunction

    task automatic predict(output hazard_pkg::stage_gates_t exp, output logic exp_halt);
        logic id_r1, id_r2, exe_r1, exe_r2, mem_r2, exe_w, mem_w, wb_w, exe_act;
        logic id_dep, exe_dep, mem_dep, ebreak, stall_all;
        id_r1   = id_valid_in && (id_class == isa_pkg::ID_BRANCH || id_class == isa_pkg::ID_JALR);
        id_r2   = id_valid_in && (id_class == isa_pkg::ID_BRANCH);
        exe_act = exe_valid_in && (exe_op != `EXE_OP_NOP);
        exe_r1  = exe_act && (exe_src == isa_pkg::SRC_R_R || exe_src == isa_pkg::SRC_R_I ||
                              exe_src == isa_pkg::SRC_R_CSR || exe_src == isa_pkg::SRC_NOTR_CSR);
        exe_r2  = exe_act && (exe_src == isa_pkg::SRC_R_R);
        mem_r2  = mem_valid_in && (mem_op >= isa_pkg::MEM_SB);  // SB to SD.
        exe_w   = exe_valid_in && sel_writes(exe_wb_sel);
        mem_w   = mem_valid_in && sel_writes(mem_wb_sel);
        wb_w    = wb_valid_in && sel_writes(wb_sel);
        id_dep  = (id_r1 && ((exe_w && id_rs1 == exe_rd) || (mem_w && id_rs1 == mem_rd) ||
                             (wb_w && id_rs1 == wb_rd))) ||
                  (id_r2 && ((exe_w && id_rs2 == exe_rd) || (mem_w && id_rs2 == mem_rd) ||
                             (wb_w && id_rs2 == wb_rd)));
        exe_dep = (exe_r1 && ((mem_w && exe_rs1 == mem_rd) || (wb_w && exe_rs1 == wb_rd))) ||
                  (exe_r2 && ((mem_w && exe_rs2 == mem_rd) || (wb_w && exe_rs2 == wb_rd)));
        mem_dep = mem_r2 && wb_w && (mem_rs2 == wb_rd);
        ebreak  = id_valid_in && (id_class == isa_pkg::ID_EBREAK);
        stall_all = id_dep || exe_dep || mem_dep || ebreak;
        exp.if_g.valid   = !(id_dep || ebreak);
        exp.if_g.enable  = !stall_all;
        exp.id_g.valid   = !(id_r1 || id_r2);
        exp.id_g.enable  = !stall_all;
        exp.exe_g.valid  = !(id_dep || ebreak);
        exp.exe_g.enable = !(exe_dep || mem_dep);
        exp.mem_g.valid  = !exe_dep;
        exp.mem_g.enable = !mem_dep;
        exp.wb_g.valid   = !mem_dep;
        exp.wb_g.enable  = 1'b1;
        exp_halt = ebreak && !exe_valid_in && !mem_valid_in && !wb_valid_in;
    endtask

    // ========================================
    // Stimulus and checks
    // ========================================

    function automatic string stage_name(input int s);
        case (s)
            0: return "if";
            1: return "id";
            2: return "exe";
            3: return "mem";
            default: return "wb";
        endcase
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic drive_random_vector();
        id_valid_in  = 1'($urandom_range(0, 1));
        id_class     = isa_pkg::id_class_e'(3'($urandom_range(0, 4)));
        id_rs1       = `REG_ADDR_W'($urandom_range(0, 3));  // Narrow range, many collisions.
        id_rs2       = `REG_ADDR_W'($urandom_range(0, 3));
        exe_valid_in = 1'($urandom_range(0, 1));
        exe_op       = 5'($urandom_range(0, 3));
        exe_src      = isa_pkg::exe_src_e'(3'($urandom_range(0, 7)));
        exe_wb_sel   = isa_pkg::wb_sel_e'(4'($urandom_range(0, 8)));
        exe_rd       = `REG_ADDR_W'($urandom_range(0, 3));
        exe_rs1      = `REG_ADDR_W'($urandom_range(0, 3));
        exe_rs2      = `REG_ADDR_W'($urandom_range(0, 3));
        mem_valid_in = 1'($urandom_range(0, 1));
        mem_op       = isa_pkg::mem_op_e'(4'($urandom_range(0, 11)));
        mem_wb_sel   = isa_pkg::wb_sel_e'(4'($urandom_range(0, 8)));
        mem_rd       = `REG_ADDR_W'($urandom_range(0, 3));
        mem_rs2      = `REG_ADDR_W'($urandom_range(0, 3));
        wb_valid_in  = 1'($urandom_range(0, 1));
        wb_sel       = isa_pkg::wb_sel_e'(4'($urandom_range(0, 8)));
        wb_rd        = `REG_ADDR_W'($urandom_range(0, 3));
    endtask

    task automatic check_outputs();
        hazard_pkg::stage_gates_t exp;
        logic                     exp_halt;
        logic [2*`NUM_STAGES-1:0] got_bits;
        logic [2*`NUM_STAGES-1:0] exp_bits;
        int                       idx;
        predict(exp, exp_halt);
        exp_bits = exp;
        got_bits = {if_valid, if_enable, id_valid, id_enable, exe_valid, exe_enable,
                    mem_valid, mem_enable, wb_valid, 1'b1};  // WB enable has no port.
        for (int s = 0; s < `NUM_STAGES; s++) begin
            idx = 2 * (`NUM_STAGES - 1 - s);
            check_bit({stage_name(s), "_valid"}, got_bits[idx + 1], exp_bits[idx + 1]);
            if (s != `NUM_STAGES - 1) begin
                check_bit({stage_name(s), "_enable"}, got_bits[idx], exp_bits[idx]);
            end
        end
        check_bit("halt", halt, exp_halt);
    endtask

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    initial begin
        void'($urandom(32'h3e5d));
        clk    = 1'b0;
        errors = 0;
        id_valid_in  = 1'b0;
        id_class     = isa_pkg::ID_NONE;
        id_rs1       = '0;
        id_rs2       = '0;
        exe_valid_in = 1'b0;
        exe_op       = `EXE_OP_NOP;
        exe_src      = isa_pkg::SRC_NOP;
        exe_wb_sel   = isa_pkg::WB_NONE;
        exe_rd       = '0;
        exe_rs1      = '0;
        exe_rs2      = '0;
        mem_valid_in = 1'b0;
        mem_op       = isa_pkg::MEM_NONE;
        mem_wb_sel   = isa_pkg::WB_NONE;
        mem_rd       = '0;
        mem_rs2      = '0;
        wb_valid_in  = 1'b0;
        wb_sel       = isa_pkg::WB_NONE;
        wb_rd        = '0;
        wait (rst == 1'b0);  // Released on a falling edge.
        for (int n = 0; n < NUM_VECTORS; n++) begin
            drive_random_vector();
            @(posedge clk);
            check_outputs();
            @(negedge clk);
        end
        $display("Checked %0d vectors, %0d errors", NUM_VECTORS, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
isa_pkg.sv
hazard_pkg.sv
stage_use_if.sv
hazard_if.sv
reg_use_decoder.sv
dependency_matcher.sv
stall_arbiter.sv
conflict_detector.sv
tb_conflict_detector.sv

/* Bender.yml */
package:
  name: conflict_detector

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - hazard_pkg.sv
      - stage_use_if.sv
      - hazard_if.sv
      - reg_use_decoder.sv
      - dependency_matcher.sv
      - stall_arbiter.sv
      - conflict_detector.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_conflict_detector.sv
